//--- Bender.yml
package:
  name: fads

export_include_dirs:
  - verilog

sources:
  - files:
      - verilog/fads_pkg.sv
      - verilog/droplet_detector.sv
      - verilog/droplet_fifo.sv
      - verilog/sort_sequencer.sv
      - verilog/fads_top.sv
  - target: test
    files:
      - tb/fads_asserts.sv
      - tb/fads_checker.sv
      - tb/tb_fads.sv

//--- tb/fads_asserts.sv
`timescale 1ns/100ps
`default_nettype none

module fads_asserts (
    input wire adc_clk_i,
    input wire fads_reset,
    input wire level_ok_i,
    input wire result_valid_i,
    input wire sort_trig_i,
    input wire in_sort_i
);

    int fail_count = 0;

    // a push into a full queue would carry occupancy past the depth
    // or split it from the pointer distance
    no_push_when_full: assert property (@(posedge adc_clk_i) disable iff (fads_reset)
        level_ok_i)
        else begin
            fail_count++;
            $error("droplet queue accepted a record while full");
        end

    result_one_cycle: assert property (@(posedge adc_clk_i) disable iff (fads_reset)
        result_valid_i |=> !result_valid_i)
        else begin
            fail_count++;
            $error("result_valid_o stayed high longer than one cycle");
        end

    // trigger only while the sequencer sits in SORT
    trig_in_sort: assert property (@(posedge adc_clk_i) disable iff (fads_reset)
        sort_trig_i |-> in_sort_i)
        else begin
            fail_count++;
            $error("sort_trig_o high outside the SORT state");
        end

endmodule

bind droplet_fifo fads_asserts u_fifo_asserts (
    .adc_clk_i      (adc_clk_i),
    .fads_reset     (fads_reset),
    .level_ok_i     ((count_q <= FULL_CNT) && ((wr_ptr_q - rd_ptr_q) == count_q[AW-1:0])),
    .result_valid_i (1'b0),
    .sort_trig_i    (1'b0),
    .in_sort_i      (1'b0)
);

bind sort_sequencer fads_asserts u_seq_asserts (
    .adc_clk_i      (adc_clk_i),
    .fads_reset     (fads_reset),
    .level_ok_i     (1'b1),
    .result_valid_i (result_valid_o),
    .sort_trig_i    (sort_trig_o),
    .in_sort_i      (state_q == fads_pkg::S_SORT)
);

`default_nettype wire

//--- tb/fads_checker.sv
`timescale 1ns/100ps
`default_nettype none

module fads_checker (
    input wire                            adc_clk_i,
    input wire                            fads_reset,
    input wire fads_pkg::fads_cfg_t       cfg_i,
    input wire fads_pkg::droplet_result_t result_i,
    input wire                            result_valid_i,
    input wire                            sort_trig_i
);

    // one expected droplet
    typedef struct packed {
        logic                  dropped;
        logic                  sort_exp;
        fads_pkg::class_t      cls;
        fads_pkg::adc_sample_t peak;
        fads_pkg::width_t      width;
    } expect_t;

    expect_t exp_q [$];

    int   error_count = 0;
    // results plus triggers still to come
    int   outstanding = 0;
    int   cycle = 0;
    int   trig_due = 0;
    int   trig_len = 0;
    logic trig_pending = 1'b0;
    logic trig_expected = 1'b0;
    logic trig_prev = 1'b0;

    fads_pkg::droplet_id_t next_id = '0;

    task automatic add_expected(input logic dropped, input logic sort_exp,
                                input fads_pkg::class_t cls, input fads_pkg::adc_sample_t peak,
                                input fads_pkg::width_t width);
        expect_t e;
        e.dropped  = dropped;
        e.sort_exp = sort_exp;
        e.cls      = cls;
        e.peak     = peak;
        e.width    = width;
        exp_q.push_back(e);
        if (!dropped) begin
            outstanding += 1 + int'(sort_exp);
        end
    endtask

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
        if (got !== want) begin
            error_count++;
            $display("mismatch %s: got %h expected %h", name, got, want);
        end
    endtask

    task automatic check_result();
        expect_t e;
        // short droplets never publish
        while (exp_q.size() > 0 && exp_q[0].dropped) begin
            e = exp_q.pop_front();
        end
        if (exp_q.size() == 0) begin
            error_count++;
            $display("error: result published at cycle %0d with no droplet expected", cycle);
        end else begin
            e = exp_q.pop_front();
            next_id = next_id + fads_pkg::droplet_id_t'(1);
            compare_field("result_o.id", result_i.id, next_id);
            compare_field("result_o.cls", result_i.cls, e.cls);
            compare_field("result_o.peak", result_i.peak, e.peak);
            compare_field("result_o.width", result_i.width, e.width);
            outstanding--;
            if (e.sort_exp) begin
                if (trig_pending) begin
                    error_count++;
                    $display("error: new sort result while the previous trigger is still due");
                end
                // delay cycles then one registered cycle
                trig_pending = 1'b1;
                trig_due     = cycle + int'(cfg_i.sort_delay) + 1;
            end
        end
    endtask

    task automatic check_trigger();
        if (sort_trig_i && !trig_prev) begin
            trig_len = 1;
            if (trig_pending && cycle == trig_due) begin
                trig_pending  = 1'b0;
                trig_expected = 1'b1;
            end else begin
                error_count++;
                trig_expected = 1'b0;
                $display("error: sort trigger rose at cycle %0d but none was due then", cycle);
            end
        end else if (sort_trig_i) begin
            trig_len++;
        end else if (trig_prev) begin
            compare_field("sort_trig_o high cycles", trig_len, cfg_i.sort_duration);
            if (trig_expected) begin
                outstanding--;
            end
            trig_expected = 1'b0;
        end
        // due cycle passed with no rising edge
        if (trig_pending && cycle >= trig_due) begin
            error_count++;
            $display("error: sort trigger did not rise at cycle %0d", trig_due);
            trig_pending = 1'b0;
            outstanding--;
        end
    endtask

    // outputs are registered, stable by the falling edge
    always @(negedge adc_clk_i) begin
        if (fads_reset) begin
            trig_prev = 1'b0;
        end else begin
            if (result_valid_i) begin
                check_result();
            end
            check_trigger();
            trig_prev = sort_trig_i;
        end
        cycle++;
    end

endmodule

`default_nettype wire

//--- tb/fads_stim.txt
# config: min_thr low_thr high_thr min_width low_width high_width sort_delay sort_duration sort_en
# droplet: peak n_stable gap class_hex sort_flag
100 1000 3000 3 5 10 20 12 1
2000 7 40 92 1
500 7 10 11 0
4000 6 10 14 0
2000 4 10 0a 0
2000 12 10 22 0
2000 2 10 00 0
100 3 10 09 0
1500 6 4 92 1
2500 5 4 92 1
1000 9 4 92 1
2200 5 4 92 1
3000 10 20 24 0

//--- tb/tb_fads.sv
`timescale 1ns/100ps
`default_nettype none

module tb_fads;

    localparam int MAX_DROPS = 32;
    // driven while stable_i is low, would spoil any peak it reached
    localparam int JUNK = 8191;

    logic                      adc_clk;
    logic                      fads_reset;
    fads_pkg::adc_sample_t     adc;
    logic                      stable;
    fads_pkg::fads_cfg_t       cfg;
    fads_pkg::droplet_result_t result;
    logic                      result_valid;
    logic                      sort_trig;

    // droplet profiles from the stim file
    int   drop_peak [MAX_DROPS];
    int   drop_n [MAX_DROPS];
    int   drop_gap [MAX_DROPS];
    int   drop_cls [MAX_DROPS];
    int   drop_sort [MAX_DROPS];
    int   num_drops = 0;
    int   stim_cycle = 0;
    int   baseline = 0;
    int   limit_cycles = 0;
    logic limit_ready = 1'b0;
    logic stim_ok = 1'b0;

    fads_top u_dut (
        .adc_clk_i      (adc_clk),
        .fads_reset     (fads_reset),
        .adc_i          (adc),
        .stable_i       (stable),
        .cfg_i          (cfg),
        .result_o       (result),
        .result_valid_o (result_valid),
        .sort_trig_o    (sort_trig)
    );

    fads_checker u_checker (
        .adc_clk_i      (adc_clk),
        .fads_reset     (fads_reset),
        .cfg_i          (cfg),
        .result_i       (result),
        .result_valid_i (result_valid),
        .sort_trig_i    (sort_trig)
    );

    initial begin
        adc_clk = 1'b0;
        forever #20 adc_clk = ~adc_clk;
    end

    // config line first, then one line per droplet
    task automatic read_stim();
        int    fd;
        int    cnt;
        int    f [9];
        string line;
        logic  have_cfg;
        have_cfg = 1'b0;
        fd = $fopen("tb/fads_stim.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                line = "";
                cnt = $fgets(line, fd);
                if (cnt > 0 && line.getc(0) != "#") begin
                    if (!have_cfg) begin
                        cnt = $sscanf(line, "%d %d %d %d %d %d %d %d %d", f[0], f[1], f[2],
                                      f[3], f[4], f[5], f[6], f[7], f[8]);
                        if (cnt == 9) begin
                            cfg.min_thr       = fads_pkg::adc_sample_t'(f[0]);
                            cfg.low_thr       = fads_pkg::adc_sample_t'(f[1]);
                            cfg.high_thr      = fads_pkg::adc_sample_t'(f[2]);
                            cfg.min_width     = fads_pkg::width_t'(f[3]);
                            cfg.low_width     = fads_pkg::width_t'(f[4]);
                            cfg.high_width    = fads_pkg::width_t'(f[5]);
                            cfg.sort_delay    = fads_pkg::time_t'(f[6]);
                            cfg.sort_duration = fads_pkg::time_t'(f[7]);
                            cfg.sort_en       = f[8][0];
                            have_cfg          = 1'b1;
                        end
                    end else if (num_drops < MAX_DROPS) begin
                        cnt = $sscanf(line, "%d %d %d %h %d", drop_peak[num_drops],
                                      drop_n[num_drops], drop_gap[num_drops],
                                      drop_cls[num_drops], drop_sort[num_drops]);
                        if (cnt == 5) begin
                            num_drops++;
                        end
                    end
                end
            end
            $fclose(fd);
        end
        stim_ok = have_cfg && (num_drops > 0);
    endtask

    // ramp from min_thr up to the peak on the middle sample and back
    function automatic int profile_sample(input int peak, input int n, input int k);
        int mid;
        int thr;
        mid = n / 2;
        thr = int'(cfg.min_thr);
        if (k == mid) begin
            return peak;
        end else if (k < mid) begin
            return thr + (peak - thr) * k / mid;
        end
        return thr + (peak - thr) * (n - 1 - k) / (n - 1 - mid);
    endfunction

    function automatic int profile_peak(input int peak, input int n);
        int best;
        int k;
        best = -(1 << 13);
        for (k = 0; k < n; k++) begin
            if (profile_sample(peak, n, k) > best) begin
                best = profile_sample(peak, n, k);
            end
        end
        return best;
    endfunction

    // twice the stream length plus one sort and some slack per droplet
    function automatic int watchdog_cycles();
        int sum;
        int i;
        sum = 0;
        for (i = 0; i < num_drops; i++) begin
            sum += (4 * drop_n[i] + 2) / 3 + drop_gap[i];
        end
        return 2 * sum + num_drops * (int'(cfg.sort_delay) + int'(cfg.sort_duration) + 10);
    endfunction

    // every fourth cycle unstable and carrying junk
    task automatic drive_cycle(input int value);
        @(negedge adc_clk);
        stable = (stim_cycle % 4) != 3;
        adc    = stable ? fads_pkg::adc_sample_t'(value) : fads_pkg::adc_sample_t'(JUNK);
        stim_cycle++;
    endtask

    task automatic drive_stable_sample(input int value);
        while ((stim_cycle % 4) == 3) begin
            drive_cycle(value);
        end
        drive_cycle(value);
    endtask

    initial begin
        int i;
        int k;
        int total;
        fads_reset = 1'b1;
        adc        = '0;
        stable     = 1'b0;
        cfg        = '0;
        read_stim();
        if (!stim_ok) begin
            $display("error: stimulus file missing or holds no droplets");
            $display("*** FAILED ***");
            $finish;
        end else begin
            baseline     = int'(cfg.min_thr) - 150;
            adc          = fads_pkg::adc_sample_t'(baseline);
            limit_cycles = watchdog_cycles();
            limit_ready  = 1'b1;
            repeat (3) @(negedge adc_clk);
            fads_reset = 1'b0;
            for (i = 0; i < num_drops; i++) begin
                // expectation goes in before the droplet starts
                u_checker.add_expected(drop_n[i] < int'(cfg.min_width), drop_sort[i][0],
                                       fads_pkg::class_t'(drop_cls[i]),
                                       fads_pkg::adc_sample_t'(profile_peak(drop_peak[i],
                                                                            drop_n[i])),
                                       fads_pkg::width_t'(drop_n[i]));
                for (k = 0; k < drop_n[i]; k++) begin
                    drive_stable_sample(profile_sample(drop_peak[i], drop_n[i], k));
                end
                for (k = 0; k < drop_gap[i]; k++) begin
                    drive_cycle(baseline);
                end
            end
            // results and triggers all seen
            wait (u_checker.outstanding == 0);
            @(negedge adc_clk);
            total = u_checker.error_count + u_dut.u_fifo.u_fifo_asserts.fail_count
                  + u_dut.u_sequencer.u_seq_asserts.fail_count;
            $display("errors: %0d checker, %0d fifo assertions, %0d sequencer assertions",
                     u_checker.error_count, u_dut.u_fifo.u_fifo_asserts.fail_count,
                     u_dut.u_sequencer.u_seq_asserts.fail_count);
            if (total == 0) begin
                $display("*** PASSED ***");
            end else begin
                $display("*** FAILED ***");
            end
            $finish;
        end
    end

    // watchdog
    initial begin
        wait (limit_ready);
        repeat (limit_cycles) @(posedge adc_clk);
        $display("error: run still busy after %0d cycles, results or triggers missing",
                 limit_cycles);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/droplet_detector.sv
`timescale 1ns/100ps
`default_nettype none

`include "fads_cfg.svh"

module droplet_detector (
    input  wire                      adc_clk_i,
    input  wire                      fads_reset,
    input  wire fads_pkg::adc_sample_t adc_i,
    input  wire                      stable_i,
    input  wire fads_pkg::adc_sample_t min_thr_i,
    output fads_pkg::droplet_rec_t   rec_o,
    output logic                     rec_valid_o,
    input  wire                      rec_ready_i
);

    fads_pkg::detect_state_t state_q;
    fads_pkg::adc_sample_t   peak_q;
    fads_pkg::width_t        width_q;
    logic                    above;

    // only stable samples count toward a droplet
    assign above = stable_i && (adc_i >= min_thr_i);

    // record stays put while held
    assign rec_o.peak  = peak_q;
    assign rec_o.width = width_q;
    assign rec_valid_o = (state_q == fads_pkg::D_HOLD);

    always_ff @(posedge adc_clk_i) begin
        if (fads_reset) begin
            state_q <= fads_pkg::D_IDLE;
            peak_q  <= `FADS_ADC_FLOOR;
            width_q <= '0;
        end else begin
            case (state_q)
                fads_pkg::D_IDLE: begin
                    // tracker sits at floor and zero here,
                    // so first sample loads peak and width 1
                    if (above) begin
                        if (adc_i > peak_q) begin
                            peak_q <= adc_i;
                        end
                        width_q <= width_q + fads_pkg::width_t'(1);
                        state_q <= fads_pkg::D_ACQUIRE;
                    end
                end
                fads_pkg::D_ACQUIRE: begin
                    if (above) begin
                        if (adc_i > peak_q) begin
                            peak_q <= adc_i;
                        end
                        width_q <= width_q + fads_pkg::width_t'(1);
                    end else if (stable_i) begin
                        // first stable sample under threshold ends it
                        state_q <= fads_pkg::D_HOLD;
                    end
                end
                fads_pkg::D_HOLD: begin
                    // samples here are dropped on the floor
                    if (rec_ready_i) begin
                        peak_q  <= `FADS_ADC_FLOOR;
                        width_q <= '0;
                        state_q <= fads_pkg::D_IDLE;
                    end
                end
                default: begin
                    state_q <= fads_pkg::D_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/droplet_fifo.sv
`timescale 1ns/100ps
`default_nettype none

`include "fads_cfg.svh"

module droplet_fifo #(
    parameter int DEPTH = `FADS_FIFO_DEPTH
) (
    input  wire                       adc_clk_i,
    input  wire                       fads_reset,
    input  wire fads_pkg::droplet_rec_t in_i,
    input  wire                       in_valid_i,
    output logic                      in_ready_o,
    output fads_pkg::droplet_rec_t    out_o,
    output logic                      out_valid_o,
    input  wire                       out_ready_i
);

    localparam int AW = $clog2(DEPTH);

    typedef logic [AW-1:0] ptr_t;
    typedef logic [AW:0]   count_t;

    localparam count_t FULL_CNT = count_t'(DEPTH);

    // record storage
    fads_pkg::droplet_rec_t mem [DEPTH];

    ptr_t   wr_ptr_q;
    ptr_t   rd_ptr_q;
    count_t count_q;
    logic   push;
    logic   pop;

    assign in_ready_o  = (count_q != FULL_CNT);
    assign out_valid_o = (count_q != '0);
    // head is always visible at the output
    assign out_o = mem[rd_ptr_q];

    assign push = in_valid_i && in_ready_o;
    assign pop  = out_valid_o && out_ready_i;

    always_ff @(posedge adc_clk_i) begin
        if (push) begin
            mem[wr_ptr_q] <= in_i;
        end
    end

    // pointers wrap on their own as depth is a power of two
    always_ff @(posedge adc_clk_i) begin
        if (fads_reset) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + ptr_t'(1);
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + ptr_t'(1);
            end
            // push and pop together leave occupancy alone
            if (push && !pop) begin
                count_q <= count_q + count_t'(1);
            end else if (pop && !push) begin
                count_q <= count_q - count_t'(1);
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/fads_cfg.svh
`ifndef FADS_CFG_SVH
`define FADS_CFG_SVH

// signed adc sample width
`define FADS_ADC_W 14
// droplet width counter, in stable samples
`define FADS_WIDTH_W 16
// sort delay and sort duration counters
`define FADS_TIME_W 16
// result numbering
`define FADS_ID_W 16
// records that may wait while a sort runs
`define FADS_FIFO_DEPTH 4
// most negative 14 bit sample, start value of the peak tracker
`define FADS_ADC_FLOOR 14'sh2000

`endif

//--- verilog/fads_pkg.sv
`default_nettype none

`include "fads_cfg.svh"

package fads_pkg;

    // plain vectors with a meaning
    typedef logic signed [`FADS_ADC_W-1:0] adc_sample_t;
    typedef logic [`FADS_WIDTH_W-1:0] width_t;
    typedef logic [`FADS_TIME_W-1:0] time_t;
    typedef logic [`FADS_ID_W-1:0] droplet_id_t;
    // [0] low int, [1] pos int, [2] high int, [3] low width
    // [4] pos width, [5] high width, [6] zero, [7] positive droplet
    typedef logic [7:0] class_t;

    // one finished droplet, detector to sequencer
    typedef struct packed {
        adc_sample_t peak;
        width_t      width;
    } droplet_rec_t;

    // steady configuration from outside
    typedef struct packed {
        adc_sample_t min_thr;
        adc_sample_t low_thr;
        adc_sample_t high_thr;
        width_t      min_width;
        width_t      low_width;
        width_t      high_width;
        time_t       sort_delay;
        time_t       sort_duration;
        logic        sort_en;
    } fads_cfg_t;

    // published per accepted droplet
    typedef struct packed {
        droplet_id_t id;
        class_t      cls;
        adc_sample_t peak;
        width_t      width;
    } droplet_result_t;

    typedef enum logic [1:0] {
        D_IDLE,
        D_ACQUIRE,
        D_HOLD
    } detect_state_t;

    typedef enum logic [1:0] {
        S_IDLE,
        S_EVAL,
        S_DELAY,
        S_SORT
    } sort_state_t;

endpackage

`default_nettype wire

//--- verilog/fads_top.sv
`timescale 1ns/100ps
`default_nettype none

module fads_top (
    input  wire                        adc_clk_i,
    input  wire                        fads_reset,
    input  wire fads_pkg::adc_sample_t adc_i,
    input  wire                        stable_i,
    input  wire fads_pkg::fads_cfg_t   cfg_i,
    output fads_pkg::droplet_result_t  result_o,
    output logic                       result_valid_o,
    output logic                       sort_trig_o
);

    // detector to queue
    fads_pkg::droplet_rec_t det_rec;
    logic                   det_valid;
    logic                   det_ready;

    // queue to sequencer
    fads_pkg::droplet_rec_t q_rec;
    logic                   q_valid;
    logic                   q_ready;

    // only the entry threshold matters for detection
    droplet_detector u_detector (
        .adc_clk_i   (adc_clk_i),
        .fads_reset  (fads_reset),
        .adc_i       (adc_i),
        .stable_i    (stable_i),
        .min_thr_i   (cfg_i.min_thr),
        .rec_o       (det_rec),
        .rec_valid_o (det_valid),
        .rec_ready_i (det_ready)
    );

    // absorbs droplets that arrive mid sort
    droplet_fifo u_fifo (
        .adc_clk_i   (adc_clk_i),
        .fads_reset  (fads_reset),
        .in_i        (det_rec),
        .in_valid_i  (det_valid),
        .in_ready_o  (det_ready),
        .out_o       (q_rec),
        .out_valid_o (q_valid),
        .out_ready_i (q_ready)
    );

    sort_sequencer u_sequencer (
        .adc_clk_i      (adc_clk_i),
        .fads_reset     (fads_reset),
        .cfg_i          (cfg_i),
        .rec_i          (q_rec),
        .rec_valid_i    (q_valid),
        .rec_ready_o    (q_ready),
        .result_o       (result_o),
        .result_valid_o (result_valid_o),
        .sort_trig_o    (sort_trig_o)
    );

endmodule

`default_nettype wire

//--- verilog/sort_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

module sort_sequencer (
    input  wire                       adc_clk_i,
    input  wire                       fads_reset,
    input  wire fads_pkg::fads_cfg_t  cfg_i,
    input  wire fads_pkg::droplet_rec_t rec_i,
    input  wire                       rec_valid_i,
    output logic                      rec_ready_o,
    output fads_pkg::droplet_result_t result_o,
    output logic                      result_valid_o,
    output logic                      sort_trig_o
);

    fads_pkg::sort_state_t  state_q;
    fads_pkg::droplet_rec_t rec_q;
    fads_pkg::droplet_id_t  id_q;
    fads_pkg::time_t        cnt_q;
    fads_pkg::class_t       cls;

    logic int_low;
    logic int_pos;
    logic int_high;
    logic wid_low;
    logic wid_pos;
    logic wid_high;
    logic positive;
    logic too_short;

    // only takes a record when nothing is in flight
    assign rec_ready_o = (state_q == fads_pkg::S_IDLE);

    // intensity bands
    assign int_low  = rec_q.peak < cfg_i.low_thr;
    assign int_pos  = (rec_q.peak >= cfg_i.low_thr) && (rec_q.peak < cfg_i.high_thr);
    assign int_high = rec_q.peak >= cfg_i.high_thr;

    // width bands
    assign wid_low  = rec_q.width < cfg_i.low_width;
    assign wid_pos  = (rec_q.width >= cfg_i.low_width) && (rec_q.width < cfg_i.high_width);
    assign wid_high = rec_q.width >= cfg_i.high_width;

    assign positive  = int_pos && wid_pos;
    assign too_short = rec_q.width < cfg_i.min_width;

    assign cls = {positive, 1'b0, wid_high, wid_pos, wid_low, int_high, int_pos, int_low};

    // record latched on transfer
    always_ff @(posedge adc_clk_i) begin
        if (rec_valid_i && rec_ready_o) begin
            rec_q <= rec_i;
        end
    end

    // result fields loaded in EVAL
    always_ff @(posedge adc_clk_i) begin
        if (state_q == fads_pkg::S_EVAL && !too_short) begin
            result_o.id    <= id_q + fads_pkg::droplet_id_t'(1);
            result_o.cls   <= cls;
            result_o.peak  <= rec_q.peak;
            result_o.width <= rec_q.width;
        end
    end

    always_ff @(posedge adc_clk_i) begin
        if (fads_reset) begin
            state_q        <= fads_pkg::S_IDLE;
            id_q           <= '0;
            cnt_q          <= '0;
            result_valid_o <= 1'b0;
            sort_trig_o    <= 1'b0;
        end else begin
            // one cycle pulse unless EVAL sets it
            result_valid_o <= 1'b0;
            case (state_q)
                fads_pkg::S_IDLE: begin
                    if (rec_valid_i) begin
                        state_q <= fads_pkg::S_EVAL;
                    end
                end
                fads_pkg::S_EVAL: begin
                    if (too_short) begin
                        // discarded without consuming an id
                        state_q <= fads_pkg::S_IDLE;
                    end else begin
                        result_valid_o <= 1'b1;
                        id_q           <= id_q + fads_pkg::droplet_id_t'(1);
                        if (positive && cfg_i.sort_en) begin
                            // zero delay skips DELAY entirely
                            if (cfg_i.sort_delay == '0) begin
                                cnt_q   <= '0;
                                state_q <= fads_pkg::S_SORT;
                            end else begin
                                cnt_q   <= fads_pkg::time_t'(1);
                                state_q <= fads_pkg::S_DELAY;
                            end
                        end else begin
                            state_q <= fads_pkg::S_IDLE;
                        end
                    end
                end
                fads_pkg::S_DELAY: begin
                    // counts 1 up to sort_delay one per cycle
                    if (cnt_q >= cfg_i.sort_delay) begin
                        cnt_q   <= '0;
                        state_q <= fads_pkg::S_SORT;
                    end else begin
                        cnt_q <= cnt_q + fads_pkg::time_t'(1);
                    end
                end
                fads_pkg::S_SORT: begin
                    // registered trigger rises one cycle into SORT
                    // and drops on the edge leaving it
                    if (cnt_q < cfg_i.sort_duration) begin
                        sort_trig_o <= 1'b1;
                        cnt_q       <= cnt_q + fads_pkg::time_t'(1);
                    end else begin
                        sort_trig_o <= 1'b0;
                        state_q     <= fads_pkg::S_IDLE;
                    end
                end
                default: begin
                    sort_trig_o <= 1'b0;
                    state_q     <= fads_pkg::S_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+verilog
verilog/fads_pkg.sv
verilog/droplet_detector.sv
verilog/droplet_fifo.sv
verilog/sort_sequencer.sv
verilog/fads_top.sv
tb/fads_asserts.sv
tb/fads_checker.sv
tb/tb_fads.sv
